// ==== node_bus.f ====
hw/node_pkg.sv
hw/message_fifo.sv
hw/basics_responder.sv
hw/echo_endpoint.sv
hw/bus_controller.sv
hw/node_top.sv
tb/tb_clock_gen.sv
tb/tb_node_top.sv

// ==== tb/tb_node_top.sv ====
`timescale 1ns/1ps

module tb_node_top import node_pkg::*; ();

	localparam logic [byte_w-1:0] ver_major = 8'd2;
	localparam logic [byte_w-1:0] ver_minor = 8'd7;
	localparam int fifo_aw = 4;

	localparam int n_rows = 18;
	localparam int max_pl = 6;
	localparam int max_pend = 4;
	localparam int max_reply = max_pl + 3;
	localparam int wait_limit = 200;

	logic              clk;
	logic              rst;
	logic [byte_w-1:0] ma_data;
	logic [byte_w-1:0] ma_addr;
	logic              ma_data_valid;
	logic              ma_frame_valid;
	logic [byte_w-1:0] sl_data;
	logic              sl_frame_valid;
	logic              sl_data_latch;
	logic              sl_overflow;

	// Stimulus table with one master frame per row
	logic [byte_w-1:0] row_addr [n_rows];
	logic [byte_w-1:0] row_eid [n_rows];
	int                row_len [n_rows];
	logic [byte_w-1:0] row_pl [n_rows][max_pl];
	int                row_drain [n_rows];
	int                row_ovf [n_rows];

	// Replies held in the node that have not been drained yet
	logic [byte_w-1:0] pend_bytes [max_pend][max_reply];
	int                pend_len [max_pend];
	int                pend_row [max_pend];
	int                pend_count;

	int ovf_count;
	int r;
	int ovf_before;
	int waited;

	tb_clock_gen i_clock_gen (
		.clk(clk),
		.rst(rst)
	);

	node_top #(
		.VERSION_MAJOR(ver_major),
		.VERSION_MINOR(ver_minor),
		.FIFO_AW(fifo_aw)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.ma_data(ma_data),
		.ma_addr(ma_addr),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.sl_data(sl_data),
		.sl_frame_valid(sl_frame_valid),
		.sl_data_latch(sl_data_latch),
		.sl_overflow(sl_overflow)
	);

	// The overflow pulse lasts one cycle, so it is counted in the middle of the cycle
	always @(negedge clk) begin
		if (sl_overflow === 1'b1)
			ovf_count <= ovf_count + 1;
	end

	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			$display("Test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic set_row(input int idx, input logic [byte_w-1:0] addr,
		input logic [byte_w-1:0] eid, input int len, input logic [byte_w-1:0] p0,
		input logic [byte_w-1:0] p1, input int drain, input int ovf);
		int i;
		row_addr[idx] = addr;
		row_eid[idx] = eid;
		row_len[idx] = len;
		row_drain[idx] = drain;
		row_ovf[idx] = ovf;
		for (i = 0; i < max_pl; i++)
			row_pl[idx][i] = '0;
		row_pl[idx][0] = p0;
		row_pl[idx][1] = p1;
		// Echo payloads come from the seeded generator
		if (addr == addr_echo) begin
			for (i = 0; i < len; i++)
				row_pl[idx][i] = byte_w'($urandom());
		end
	endtask

	task automatic send_frame(input int idx);
		int i;
		step_cycle();
		ma_addr = row_addr[idx];
		ma_frame_valid = 1'b1;
		ma_data_valid = 1'b1;
		ma_data = row_eid[idx];
		step_cycle();
		ma_data = byte_w'(row_len[idx]);
		for (i = 0; i < row_len[idx]; i++) begin
			step_cycle();
			ma_data = row_pl[idx][i];
		end
		step_cycle();
		ma_frame_valid = 1'b0;
		ma_data_valid = 1'b0;
		ma_data = '0;
		// Idle gap long enough for the slowest endpoint to commit its reply
		repeat (6) step_cycle();
	endtask

	// Expected reply built from the reply formats of each service
	task automatic queue_reply(input int idx);
		int k;
		int i;
		k = pend_count;
		pend_row[k] = idx;
		pend_bytes[k][0] = row_addr[idx];
		pend_bytes[k][1] = 8'd2;
		pend_bytes[k][2] = row_eid[idx];
		pend_len[k] = 4;
		if (row_addr[idx] == addr_echo) begin
			pend_bytes[k][1] = byte_w'(row_len[idx] + 1);
			for (i = 0; i < row_len[idx]; i++)
				pend_bytes[k][3+i] = row_pl[idx][i];
			pend_len[k] = row_len[idx] + 3;
		end else if (row_addr[idx] == addr_query) begin
			pend_bytes[k][3] = code_ack;
		end else if (row_addr[idx] == addr_version) begin
			if (row_pl[idx][0] == ver_major && row_pl[idx][1] == ver_minor) begin
				pend_bytes[k][3] = code_ack;
			end else begin
				pend_bytes[k][1] = 8'd4;
				pend_bytes[k][3] = code_nak;
				pend_bytes[k][4] = ver_major;
				pend_bytes[k][5] = ver_minor;
				pend_len[k] = 6;
			end
		end else begin
			pend_bytes[k][3] = code_nak;
		end
		pend_count = pend_count + 1;
	endtask

	task automatic drain_pending();
		int idx;
		int wait_cnt;
		int i;
		int j;
		while (pend_count > 0) begin
			wait_cnt = 0;
			while (sl_frame_valid !== 1'b1 && wait_cnt < wait_limit) begin
				step_cycle();
				wait_cnt++;
			end
			if (sl_frame_valid !== 1'b1) begin
				$display("Timeout: the reply to row %0d (address %02h) never reached the slave bus",
					pend_row[0], pend_bytes[0][0]);
				$display("Test failed");
				$fatal(1, "slave bus timeout");
			end

			// Replies may come in either order, so the address byte picks the oldest match
			idx = 0;
			for (i = pend_count - 1; i >= 0; i--) begin
				if (pend_bytes[i][0] == sl_data)
					idx = i;
			end

			for (i = 0; i < pend_len[idx]; i++) begin
				check_value("sl_frame_valid", 1, sl_frame_valid);
				check_value("sl_data", pend_bytes[idx][i], sl_data);
				sl_data_latch = 1'b1;
				step_cycle();
				sl_data_latch = 1'b0;
			end
			check_value("sl_frame_valid", 0, sl_frame_valid);

			for (i = idx; i < pend_count - 1; i++) begin
				pend_len[i] = pend_len[i+1];
				pend_row[i] = pend_row[i+1];
				for (j = 0; j < max_reply; j++)
					pend_bytes[i][j] = pend_bytes[i+1][j];
			end
			pend_count = pend_count - 1;
		end
	endtask

	initial begin
		ma_data = '0;
		ma_addr = '0;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		sl_data_latch = 1'b0;
		ovf_count = 0;
		pend_count = 0;
		void'($urandom(32'hdf0e_da96));

		//      row addr          eid    len p0     p1     drain ovf
		set_row(0,  addr_query,   8'h11, 0, 8'h00, 8'h00, 1, 0);
		set_row(1,  addr_version, 8'h21, 2, 8'h02, 8'h07, 1, 0);
		set_row(2,  addr_version, 8'h22, 2, 8'h03, 8'h01, 1, 0);
		set_row(3,  8'h10,        8'h31, 0, 8'h00, 8'h00, 1, 0);
		set_row(4,  8'hc4,        8'h32, 0, 8'h00, 8'h00, 1, 0);
		set_row(5,  addr_echo,    8'h41, 1, 8'h00, 8'h00, 1, 0);
		set_row(6,  addr_echo,    8'h42, 2, 8'h00, 8'h00, 1, 0);
		set_row(7,  addr_echo,    8'h43, 3, 8'h00, 8'h00, 1, 0);
		set_row(8,  addr_echo,    8'h44, 4, 8'h00, 8'h00, 1, 0);
		set_row(9,  addr_echo,    8'h45, 5, 8'h00, 8'h00, 1, 0);
		set_row(10, addr_echo,    8'h46, 6, 8'h00, 8'h00, 1, 0);
		// Two endpoints hold a reply at the same time
		set_row(11, addr_echo,    8'h51, 3, 8'h00, 8'h00, 0, 0);
		set_row(12, addr_version, 8'h52, 2, 8'h03, 8'h01, 1, 0);
		set_row(13, addr_version, 8'h53, 2, 8'h02, 8'h07, 0, 0);
		set_row(14, addr_echo,    8'h54, 5, 8'h00, 8'h00, 1, 0);
		// The third 7 byte frame no longer fits in a 16 entry FIFO
		set_row(15, addr_echo,    8'h61, 4, 8'h00, 8'h00, 0, 0);
		set_row(16, addr_echo,    8'h62, 4, 8'h00, 8'h00, 0, 0);
		set_row(17, addr_echo,    8'h63, 4, 8'h00, 8'h00, 1, 1);

		waited = 0;
		while (rst !== 1'b0 && waited < 20) begin
			step_cycle();
			waited++;
		end
		if (rst !== 1'b0) begin
			$display("Reset was never released");
			$display("Test failed");
			$fatal(1, "reset stuck high");
		end
		step_cycle();
		check_value("sl_frame_valid", 0, sl_frame_valid);
		check_value("sl_overflow", 0, sl_overflow);

		for (r = 0; r < n_rows; r++) begin
			ovf_before = ovf_count;
			send_frame(r);
			check_value("sl_overflow pulses", row_ovf[r], ovf_count - ovf_before);
			if (row_ovf[r] == 0)
				queue_reply(r);
			if (row_drain[r] != 0)
				drain_pending();
		end

		// Nothing is left behind once the stored frames are drained
		repeat (20) begin
			check_value("sl_frame_valid", 0, sl_frame_valid);
			step_cycle();
		end

		$display("Test passed");
		$finish;
	end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int half_period = 5,
	parameter int reset_cycles = 2
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// Reset drops just after a rising edge, in the same phase as the other stimulus
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// ==== hw/node_top.sv ====
`timescale 1ns/1ps

module node_top import node_pkg::*; #(
	parameter logic [byte_w-1:0] VERSION_MAJOR = 8'd1,
	parameter logic [byte_w-1:0] VERSION_MINOR = 8'd0,
	parameter int                FIFO_AW = 4
) (
	input  logic              clk,
	input  logic              rst,

	input  logic [byte_w-1:0] ma_data,
	input  logic [byte_w-1:0] ma_addr,
	input  logic              ma_data_valid,
	input  logic              ma_frame_valid,

	output logic [byte_w-1:0] sl_data,
	output logic              sl_frame_valid,
	input  logic              sl_data_latch,
	output logic              sl_overflow
);

	logic              generate_nak;
	logic              query_start;
	logic              version_start;
	logic              echo_start;

	logic [byte_w-1:0] basics_data;
	logic              basics_frame_valid;
	logic              basics_data_latch;
	logic              basics_overflow;

	logic [byte_w-1:0] echo_data;
	logic              echo_frame_valid;
	logic              echo_data_latch;
	logic              echo_overflow;

	// Either endpoint may lose a frame, and the outside sees one pulse
	assign sl_overflow = basics_overflow || echo_overflow;

	bus_controller i_bus_controller (
		.clk(clk),
		.rst(rst),
		.ma_addr(ma_addr),
		.ma_frame_valid(ma_frame_valid),
		.generate_nak(generate_nak),
		.query_start(query_start),
		.version_start(version_start),
		.echo_start(echo_start),
		.basics_data(basics_data),
		.basics_frame_valid(basics_frame_valid),
		.basics_data_latch(basics_data_latch),
		.echo_data(echo_data),
		.echo_frame_valid(echo_frame_valid),
		.echo_data_latch(echo_data_latch),
		.sl_data(sl_data),
		.sl_frame_valid(sl_frame_valid),
		.sl_data_latch(sl_data_latch)
	);

	basics_responder #(
		.VERSION_MAJOR(VERSION_MAJOR),
		.VERSION_MINOR(VERSION_MINOR),
		.FIFO_AW(FIFO_AW)
	) i_basics_responder (
		.clk(clk),
		.rst(rst),
		.generate_nak(generate_nak),
		.query_start(query_start),
		.version_start(version_start),
		.ma_data(ma_data),
		.ma_addr(ma_addr),
		.ma_data_valid(ma_data_valid),
		.out_data(basics_data),
		.out_frame_valid(basics_frame_valid),
		.out_data_latch(basics_data_latch),
		.overflow(basics_overflow)
	);

	echo_endpoint #(
		.FIFO_AW(FIFO_AW)
	) i_echo_endpoint (
		.clk(clk),
		.rst(rst),
		.echo_start(echo_start),
		.ma_data(ma_data),
		.ma_addr(ma_addr),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.out_data(echo_data),
		.out_frame_valid(echo_frame_valid),
		.out_data_latch(echo_data_latch),
		.overflow(echo_overflow)
	);

endmodule

// ==== hw/bus_controller.sv ====
`timescale 1ns/1ps

module bus_controller import node_pkg::*; (
	input  logic              clk,
	input  logic              rst,

	input  logic [byte_w-1:0] ma_addr,
	input  logic              ma_frame_valid,
	output logic              generate_nak,
	output logic              query_start,
	output logic              version_start,
	output logic              echo_start,

	input  logic [byte_w-1:0] basics_data,
	input  logic              basics_frame_valid,
	output logic              basics_data_latch,
	input  logic [byte_w-1:0] echo_data,
	input  logic              echo_frame_valid,
	output logic              echo_data_latch,

	output logic [byte_w-1:0] sl_data,
	output logic              sl_frame_valid,
	input  logic              sl_data_latch
);

	logic frame_valid_q;
	logic frame_start;
	logic addr_known;
	logic busy;
	logic sel_echo;
	logic prio_echo;
	logic pick_echo;

	// Strobes fire in the first cycle of a master frame only
	assign frame_start = ma_frame_valid && !frame_valid_q;
	assign addr_known = (ma_addr == addr_query) || (ma_addr == addr_version) ||
		(ma_addr == addr_echo);

	assign query_start = frame_start && (ma_addr == addr_query);
	assign version_start = frame_start && (ma_addr == addr_version);
	assign echo_start = frame_start && (ma_addr == addr_echo);
	assign generate_nak = frame_start && !addr_known;

	// When both FIFOs ask, the one that was not served last time wins
	assign pick_echo = echo_frame_valid && (!basics_frame_valid || prio_echo);

	assign sl_frame_valid = busy && (sel_echo ? echo_frame_valid : basics_frame_valid);
	assign sl_data = sel_echo ? echo_data : basics_data;
	assign basics_data_latch = sl_data_latch && busy && !sel_echo;
	assign echo_data_latch = sl_data_latch && busy && sel_echo;

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_valid_q <= 1'b0;
			busy <= 1'b0;
			sel_echo <= 1'b0;
			prio_echo <= 1'b0;
		end else begin
			frame_valid_q <= ma_frame_valid;
			if (!busy) begin
				if (basics_frame_valid || echo_frame_valid) begin
					busy <= 1'b1;
					sel_echo <= pick_echo;
					prio_echo <= !pick_echo;
				end
			end else if (!sl_frame_valid) begin
				busy <= 1'b0;
			end
		end
	end

	// A frame on the slave bus holds its byte until the consumer takes it
	assert property (@(posedge clk) disable iff (rst)
		sl_frame_valid && !sl_data_latch |=> sl_frame_valid && $stable(sl_data));

endmodule

// ==== hw/echo_endpoint.sv ====
`timescale 1ns/1ps

module echo_endpoint import node_pkg::*; #(
	parameter int FIFO_AW = 4
) (
	input  logic              clk,
	input  logic              rst,

	input  logic              echo_start,
	input  logic [byte_w-1:0] ma_data,
	input  logic [byte_w-1:0] ma_addr,
	input  logic              ma_data_valid,
	input  logic              ma_frame_valid,

	output logic [byte_w-1:0] out_data,
	output logic              out_frame_valid,
	input  logic              out_data_latch,
	output logic              overflow
);

	logic              active;
	logic              len_seen;
	logic              push_q;
	logic [byte_w-1:0] data_q;

	logic [byte_w-1:0] in_data;
	logic              in_data_latch;
	logic              in_frame_valid;

	// The address goes in with the strobe, every kept master byte one cycle late
	assign in_frame_valid = echo_start || active;
	assign in_data_latch = echo_start || push_q;
	assign in_data = echo_start ? ma_addr : data_q;

	message_fifo #(
		.FIFO_AW(FIFO_AW)
	) i_fifo (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.in_data_latch(in_data_latch),
		.in_frame_valid(in_frame_valid),
		.in_data_overflow(overflow),
		.out_data(out_data),
		.out_frame_valid(out_frame_valid),
		.out_data_latch(out_data_latch)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			len_seen <= 1'b0;
			push_q <= 1'b0;
		end else begin
			push_q <= 1'b0;
			if (echo_start) begin
				active <= 1'b1;
				len_seen <= 1'b0;
				push_q <= ma_data_valid;
			end else if (active) begin
				if (!ma_frame_valid)
					active <= 1'b0;
				else if (ma_data_valid) begin
					// The master length byte is dropped since the FIFO writes its own
					if (len_seen)
						push_q <= 1'b1;
					else
						len_seen <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		data_q <= ma_data;
	end

endmodule

// ==== hw/basics_responder.sv ====
`timescale 1ns/1ps

module basics_responder import node_pkg::*; #(
	parameter logic [byte_w-1:0] VERSION_MAJOR = 8'd1,
	parameter logic [byte_w-1:0] VERSION_MINOR = 8'd0,
	parameter int                FIFO_AW = 4
) (
	input  logic              clk,
	input  logic              rst,

	input  logic              generate_nak,
	input  logic              query_start,
	input  logic              version_start,

	input  logic [byte_w-1:0] ma_data,
	input  logic [byte_w-1:0] ma_addr,
	input  logic              ma_data_valid,

	output logic [byte_w-1:0] out_data,
	output logic              out_frame_valid,
	input  logic              out_data_latch,
	output logic              overflow
);

	localparam logic [3:0] st_idle = 4'd0;
	localparam logic [3:0] st_skip_len = 4'd1;
	localparam logic [3:0] st_nak = 4'd2;
	localparam logic [3:0] st_query = 4'd3;
	localparam logic [3:0] st_ver_hi = 4'd4;
	localparam logic [3:0] st_ver_lo = 4'd5;
	localparam logic [3:0] st_ver_check = 4'd6;
	localparam logic [3:0] st_ver_major = 4'd7;
	localparam logic [3:0] st_ver_minor = 4'd8;

	logic [3:0]          state;
	logic [3:0]          next_state;
	logic                any_start;
	logic                cmd_query;
	logic                cmd_version;
	logic [byte_w-1:0]   latched_eid;
	logic [2*byte_w-1:0] version_in;
	logic                version_match;
	logic                shift_ver;

	logic [byte_w-1:0]   in_data;
	logic                in_data_latch;
	logic                in_frame_valid;

	assign any_start = generate_nak || query_start || version_start;
	assign version_match = (version_in == {VERSION_MAJOR, VERSION_MINOR});

	message_fifo #(
		.FIFO_AW(FIFO_AW)
	) i_fifo (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.in_data_latch(in_data_latch),
		.in_frame_valid(in_frame_valid),
		.in_data_overflow(overflow),
		.out_data(out_data),
		.out_frame_valid(out_frame_valid),
		.out_data_latch(out_data_latch)
	);

	// The reply frame stays open from the strobe cycle until the FSM is back in idle
	always_comb begin
		next_state = state;
		in_frame_valid = 1'b1;
		in_data_latch = 1'b0;
		in_data = latched_eid;
		shift_ver = 1'b0;

		case (state)
			st_idle: begin
				in_frame_valid = any_start;
				in_data_latch = any_start;
				in_data = ma_addr;
				if (any_start)
					next_state = st_skip_len;
			end

			// The EID goes out as the master length byte passes by
			st_skip_len: begin
				in_data_latch = ma_data_valid;
				if (ma_data_valid) begin
					if (cmd_version)
						next_state = st_ver_hi;
					else if (cmd_query)
						next_state = st_query;
					else
						next_state = st_nak;
				end
			end

			st_nak: begin
				in_data_latch = 1'b1;
				in_data = code_nak;
				next_state = st_idle;
			end

			// Nothing beyond an acknowledge is defined for the query service yet
			st_query: begin
				in_data_latch = 1'b1;
				in_data = code_ack;
				next_state = st_idle;
			end

			st_ver_hi: begin
				shift_ver = ma_data_valid;
				if (ma_data_valid)
					next_state = st_ver_lo;
			end

			st_ver_lo: begin
				shift_ver = ma_data_valid;
				if (ma_data_valid)
					next_state = st_ver_check;
			end

			st_ver_check: begin
				in_data_latch = 1'b1;
				in_data = version_match ? code_ack : code_nak;
				next_state = version_match ? st_idle : st_ver_major;
			end

			// On a mismatch the master learns which version this node runs
			st_ver_major: begin
				in_data_latch = 1'b1;
				in_data = VERSION_MAJOR;
				next_state = st_ver_minor;
			end

			st_ver_minor: begin
				in_data_latch = 1'b1;
				in_data = VERSION_MINOR;
				next_state = st_idle;
			end

			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			cmd_query <= 1'b0;
			cmd_version <= 1'b0;
		end else begin
			state <= next_state;
			if (state == st_idle && any_start) begin
				cmd_query <= query_start;
				cmd_version <= version_start;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && any_start)
			latched_eid <= ma_data;
		if (shift_ver)
			version_in <= {version_in[byte_w-1:0], ma_data};
	end

	// The controller decodes one address per frame, so only one service may start
	assert property (@(posedge clk) disable iff (rst)
		$onehot0({generate_nak, query_start, version_start}));

endmodule

// ==== hw/message_fifo.sv ====
`timescale 1ns/1ps

module message_fifo import node_pkg::*; #(
	parameter int FIFO_AW = 4
) (
	input  logic              clk,
	input  logic              rst,

	input  logic [byte_w-1:0] in_data,
	input  logic              in_data_latch,
	input  logic              in_frame_valid,
	output logic              in_data_overflow,

	output logic [byte_w-1:0] out_data,
	output logic              out_frame_valid,
	input  logic              out_data_latch
);

	localparam int depth = 1 << FIFO_AW;

	localparam logic [1:0] rd_addr = 2'd0;
	localparam logic [1:0] rd_len = 2'd1;
	localparam logic [1:0] rd_body = 2'd2;

	logic [byte_w-1:0] mem [depth];

	// Pointers carry one extra bit so that full and empty differ
	logic [FIFO_AW:0]   wr_ptr;
	logic [FIFO_AW:0]   commit_ptr;
	logic [FIFO_AW:0]   rd_ptr;
	logic [FIFO_AW:0]   used;
	logic [FIFO_AW:0]   wr_step;
	logic [FIFO_AW:0]   frame_len;
	logic [FIFO_AW-1:0] len_slot;

	logic              in_frame_valid_q;
	logic              frame_ovf;
	logic              first_byte;
	logic              fits;
	logic              do_write;
	logic              commit;
	logic              commit_ok;

	logic [1:0]        rd_phase;
	logic [byte_w-1:0] rd_remain;
	logic              rd_gap;
	logic              rd_take;

	assign used = wr_ptr - rd_ptr;
	assign first_byte = (wr_ptr == commit_ptr);

	// The first byte of a frame also claims the slot behind it for the length
	assign fits = first_byte ? (used < depth - 1) : (used < depth);
	assign wr_step = first_byte ? (FIFO_AW+1)'(2) : (FIFO_AW+1)'(1);
	assign do_write = in_data_latch && in_frame_valid && !frame_ovf && fits;

	assign commit = in_frame_valid_q && !in_frame_valid;
	assign commit_ok = commit && !frame_ovf && !first_byte;
	assign frame_len = wr_ptr - commit_ptr - (FIFO_AW+1)'(2);
	assign len_slot = commit_ptr[FIFO_AW-1:0] + 1'b1;
	assign in_data_overflow = commit && frame_ovf;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			commit_ptr <= '0;
			frame_ovf <= 1'b0;
			in_frame_valid_q <= 1'b0;
		end else begin
			in_frame_valid_q <= in_frame_valid;
			if (do_write)
				wr_ptr <= wr_ptr + wr_step;
			else if (in_data_latch && in_frame_valid && !fits)
				frame_ovf <= 1'b1;

			// A frame that did not fit is thrown away as a whole
			if (commit) begin
				frame_ovf <= 1'b0;
				if (frame_ovf)
					wr_ptr <= commit_ptr;
				else if (!first_byte)
					commit_ptr <= wr_ptr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr[FIFO_AW-1:0]] <= in_data;
		else if (commit_ok)
			mem[len_slot] <= byte_w'(frame_len);
	end

	// Read side walks address, length and then the counted body bytes
	assign out_data = mem[rd_ptr[FIFO_AW-1:0]];
	assign out_frame_valid = (rd_ptr != commit_ptr) && !rd_gap;
	assign rd_take = out_data_latch && out_frame_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			rd_phase <= rd_addr;
			rd_remain <= '0;
			rd_gap <= 1'b0;
		end else begin
			rd_gap <= 1'b0;
			if (rd_take) begin
				rd_ptr <= rd_ptr + 1'b1;
				case (rd_phase)
					rd_addr: rd_phase <= rd_len;
					rd_len: begin
						rd_phase <= rd_body;
						rd_remain <= out_data;
					end
					default: begin
						rd_remain <= rd_remain - 1'b1;
						if (rd_remain == 1) begin
							rd_phase <= rd_addr;
							rd_gap <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	// The slave side must only pull bytes while a frame is offered
	assert property (@(posedge clk) disable iff (rst) out_data_latch |-> out_frame_valid);

endmodule

// ==== hw/node_pkg.sv ====
package node_pkg;

	// Every bus in the node moves one byte per transfer
	localparam int byte_w = 8;

	// Service addresses decoded by the bus controller
	localparam logic [byte_w-1:0] addr_query = 8'h3F;
	localparam logic [byte_w-1:0] addr_version = 8'h56;
	localparam logic [byte_w-1:0] addr_echo = 8'h45;

	// Response codes placed after the EID in a reply
	localparam logic [byte_w-1:0] code_ack = 8'h00;
	localparam logic [byte_w-1:0] code_nak = 8'h01;

endpackage
